// File: source/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // number of entries, fully associative
    localparam int TLB_NUM = 16;

    // width of w_index, r_index and the search hit index
    localparam int INDEX_W = $clog2(TLB_NUM);

    // tag part of an entry
    //   vpn2  asid  g
    //    19     8   1
    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;

    // each page half, even and odd
    //   pfn  c  d  v
    //    20  3  1  1
    localparam int PFN_W   = 20;
    localparam int CATTR_W = 3;

endpackage

`default_nettype wire

// File: source/tlb_entry_array.sv
`default_nettype none

module tlb_entry_array (
    input  wire                                            clk,
    input  wire                                            rst,

    // write port
    input  wire                                            we,
    input  wire  [tlb_pkg::INDEX_W-1:0]                    w_index,
    input  wire  [tlb_pkg::VPN2_W-1:0]                     w_vpn2,
    input  wire  [tlb_pkg::ASID_W-1:0]                     w_asid,
    input  wire                                            w_g,
    input  wire  [tlb_pkg::PFN_W-1:0]                      w_pfn0,
    input  wire  [tlb_pkg::CATTR_W-1:0]                    w_c0,
    input  wire                                            w_d0,
    input  wire                                            w_v0,
    input  wire  [tlb_pkg::PFN_W-1:0]                      w_pfn1,
    input  wire  [tlb_pkg::CATTR_W-1:0]                    w_c1,
    input  wire                                            w_d1,
    input  wire                                            w_v1,

    // read port
    input  wire  [tlb_pkg::INDEX_W-1:0]                    r_index,
    output logic [tlb_pkg::VPN2_W-1:0]                     r_vpn2,
    output logic [tlb_pkg::ASID_W-1:0]                     r_asid,
    output logic                                           r_g,
    output logic [tlb_pkg::PFN_W-1:0]                      r_pfn0,
    output logic [tlb_pkg::CATTR_W-1:0]                    r_c0,
    output logic                                           r_d0,
    output logic                                           r_v0,
    output logic [tlb_pkg::PFN_W-1:0]                      r_pfn1,
    output logic [tlb_pkg::CATTR_W-1:0]                    r_c1,
    output logic                                           r_d1,
    output logic                                           r_v1,

    // every entry, flattened, for the search paths
    output logic [tlb_pkg::TLB_NUM*tlb_pkg::VPN2_W-1:0]    entry_vpn2,
    output logic [tlb_pkg::TLB_NUM*tlb_pkg::ASID_W-1:0]    entry_asid,
    output logic [tlb_pkg::TLB_NUM-1:0]                    entry_g,
    output logic [tlb_pkg::TLB_NUM*tlb_pkg::PFN_W-1:0]     entry_pfn0,
    output logic [tlb_pkg::TLB_NUM*tlb_pkg::CATTR_W-1:0]   entry_c0,
    output logic [tlb_pkg::TLB_NUM-1:0]                    entry_d0,
    output logic [tlb_pkg::TLB_NUM-1:0]                    entry_v0,
    output logic [tlb_pkg::TLB_NUM*tlb_pkg::PFN_W-1:0]     entry_pfn1,
    output logic [tlb_pkg::TLB_NUM*tlb_pkg::CATTR_W-1:0]   entry_c1,
    output logic [tlb_pkg::TLB_NUM-1:0]                    entry_d1,
    output logic [tlb_pkg::TLB_NUM-1:0]                    entry_v1
);

    logic [tlb_pkg::TLB_NUM-1:0][tlb_pkg::VPN2_W-1:0]  vpn2_q;
    logic [tlb_pkg::TLB_NUM-1:0][tlb_pkg::ASID_W-1:0]  asid_q;
    logic [tlb_pkg::TLB_NUM-1:0]                       g_q;
    logic [tlb_pkg::TLB_NUM-1:0][tlb_pkg::PFN_W-1:0]   pfn0_q;
    logic [tlb_pkg::TLB_NUM-1:0][tlb_pkg::CATTR_W-1:0] c0_q;
    logic [tlb_pkg::TLB_NUM-1:0]                       d0_q;
    logic [tlb_pkg::TLB_NUM-1:0]                       v0_q;
    logic [tlb_pkg::TLB_NUM-1:0][tlb_pkg::PFN_W-1:0]   pfn1_q;
    logic [tlb_pkg::TLB_NUM-1:0][tlb_pkg::CATTR_W-1:0] c1_q;
    logic [tlb_pkg::TLB_NUM-1:0]                       d1_q;
    logic [tlb_pkg::TLB_NUM-1:0]                       v1_q;

    // a cleared entry must not look like a usable translation
    always_ff @(posedge clk) begin
        if (!rst) begin
            vpn2_q <= '0;
            asid_q <= '0;
            g_q    <= '0;
            pfn0_q <= '0;
            c0_q   <= '0;
            d0_q   <= '0;
            v0_q   <= '0;
            pfn1_q <= '0;
            c1_q   <= '0;
            d1_q   <= '0;
            v1_q   <= '0;
        end else if (we) begin
            vpn2_q[w_index] <= w_vpn2;
            asid_q[w_index] <= w_asid;
            g_q[w_index]    <= w_g;
            pfn0_q[w_index] <= w_pfn0;
            c0_q[w_index]   <= w_c0;
            d0_q[w_index]   <= w_d0;
            v0_q[w_index]   <= w_v0;
            pfn1_q[w_index] <= w_pfn1;
            c1_q[w_index]   <= w_c1;
            d1_q[w_index]   <= w_d1;
            v1_q[w_index]   <= w_v1;
        end
    end

    // read port sees the registered contents, so old data on a same-cycle write
    assign r_vpn2 = vpn2_q[r_index];
    assign r_asid = asid_q[r_index];
    assign r_g    = g_q[r_index];
    assign r_pfn0 = pfn0_q[r_index];
    assign r_c0   = c0_q[r_index];
    assign r_d0   = d0_q[r_index];
    assign r_v0   = v0_q[r_index];
    assign r_pfn1 = pfn1_q[r_index];
    assign r_c1   = c1_q[r_index];
    assign r_d1   = d1_q[r_index];
    assign r_v1   = v1_q[r_index];

    // entry k sits at slice k of each flat vector
    assign entry_vpn2 = vpn2_q;
    assign entry_asid = asid_q;
    assign entry_g    = g_q;
    assign entry_pfn0 = pfn0_q;
    assign entry_c0   = c0_q;
    assign entry_d0   = d0_q;
    assign entry_v0   = v0_q;
    assign entry_pfn1 = pfn1_q;
    assign entry_c1   = c1_q;
    assign entry_d1   = d1_q;
    assign entry_v1   = v1_q;

endmodule

`default_nettype wire

// File: source/tlb_match.sv
`default_nettype none

module tlb_match (
    input  wire  [tlb_pkg::VPN2_W-1:0]                  vpn2,
    input  wire  [tlb_pkg::ASID_W-1:0]                  asid,
    input  wire  [tlb_pkg::TLB_NUM*tlb_pkg::VPN2_W-1:0] entry_vpn2,
    input  wire  [tlb_pkg::TLB_NUM*tlb_pkg::ASID_W-1:0] entry_asid,
    input  wire  [tlb_pkg::TLB_NUM-1:0]                 entry_g,
    output logic [tlb_pkg::TLB_NUM-1:0]                 match,
    output logic                                        found
);

    logic [tlb_pkg::TLB_NUM-1:0] vpn2_eq;
    logic [tlb_pkg::TLB_NUM-1:0] asid_eq;

    // one comparator pair per entry
    for (genvar k = 0; k < tlb_pkg::TLB_NUM; k++) begin : g_cmp
        assign vpn2_eq[k] =
            (entry_vpn2[k*tlb_pkg::VPN2_W +: tlb_pkg::VPN2_W] == vpn2);
        assign asid_eq[k] =
            (entry_asid[k*tlb_pkg::ASID_W +: tlb_pkg::ASID_W] == asid);
    end

    // global entries ignore the asid
    assign match = vpn2_eq & (asid_eq | entry_g);

    // more than one hit is a software error, found stays high regardless
    assign found = |match;

endmodule

`default_nettype wire

// File: source/tlb_page_select.sv
`default_nettype none

module tlb_page_select (
    input  wire  [tlb_pkg::TLB_NUM-1:0]                   match,
    input  wire                                           odd_page,

    // even page half of every entry
    input  wire  [tlb_pkg::TLB_NUM*tlb_pkg::PFN_W-1:0]    entry_pfn0,
    input  wire  [tlb_pkg::TLB_NUM*tlb_pkg::CATTR_W-1:0]  entry_c0,
    input  wire  [tlb_pkg::TLB_NUM-1:0]                   entry_d0,
    input  wire  [tlb_pkg::TLB_NUM-1:0]                   entry_v0,

    // odd page half of every entry
    input  wire  [tlb_pkg::TLB_NUM*tlb_pkg::PFN_W-1:0]    entry_pfn1,
    input  wire  [tlb_pkg::TLB_NUM*tlb_pkg::CATTR_W-1:0]  entry_c1,
    input  wire  [tlb_pkg::TLB_NUM-1:0]                   entry_d1,
    input  wire  [tlb_pkg::TLB_NUM-1:0]                   entry_v1,

    output logic [tlb_pkg::INDEX_W-1:0]                   index,
    output logic [tlb_pkg::PFN_W-1:0]                     pfn,
    output logic [tlb_pkg::CATTR_W-1:0]                   c,
    output logic                                          d,
    output logic                                          v
);

    logic [tlb_pkg::PFN_W-1:0]   pfn_even;
    logic [tlb_pkg::PFN_W-1:0]   pfn_odd;
    logic [tlb_pkg::CATTR_W-1:0] c_even;
    logic [tlb_pkg::CATTR_W-1:0] c_odd;
    logic                        d_even;
    logic                        d_odd;
    logic                        v_even;
    logic                        v_odd;

    // one-hot to binary, each hit contributes its own entry number
    always_comb begin : encode_index
        index = '0;
        for (int k = 0; k < tlb_pkg::TLB_NUM; k++) begin
            index = index | ({tlb_pkg::INDEX_W{match[k]}} & k[tlb_pkg::INDEX_W-1:0]);
        end
    end

    // and-or select, a zero match gives all zeros
    always_comb begin : select_pfn
        pfn_even = '0;
        pfn_odd  = '0;
        for (int k = 0; k < tlb_pkg::TLB_NUM; k++) begin
            pfn_even = pfn_even | ({tlb_pkg::PFN_W{match[k]}}
                       & entry_pfn0[k*tlb_pkg::PFN_W +: tlb_pkg::PFN_W]);
            pfn_odd  = pfn_odd | ({tlb_pkg::PFN_W{match[k]}}
                       & entry_pfn1[k*tlb_pkg::PFN_W +: tlb_pkg::PFN_W]);
        end
    end

    always_comb begin : select_cattr
        c_even = '0;
        c_odd  = '0;
        for (int k = 0; k < tlb_pkg::TLB_NUM; k++) begin
            c_even = c_even | ({tlb_pkg::CATTR_W{match[k]}}
                     & entry_c0[k*tlb_pkg::CATTR_W +: tlb_pkg::CATTR_W]);
            c_odd  = c_odd | ({tlb_pkg::CATTR_W{match[k]}}
                     & entry_c1[k*tlb_pkg::CATTR_W +: tlb_pkg::CATTR_W]);
        end
    end

    // single-bit fields reduce directly
    assign d_even = |(match & entry_d0);
    assign d_odd  = |(match & entry_d1);
    assign v_even = |(match & entry_v0);
    assign v_odd  = |(match & entry_v1);

    // odd_page picks the half of the pair
    assign pfn = odd_page ? pfn_odd : pfn_even;
    assign c   = odd_page ? c_odd   : c_even;
    assign d   = odd_page ? d_odd   : d_even;
    assign v   = odd_page ? v_odd   : v_even;

endmodule

`default_nettype wire

// File: source/tlb_top.sv
`default_nettype none

module tlb_top (
    input  wire                          clk,
    input  wire                          rst,

    // search port 0
    input  wire  [tlb_pkg::VPN2_W-1:0]   s0_vpn2,
    input  wire                          s0_odd_page,
    input  wire  [tlb_pkg::ASID_W-1:0]   s0_asid,
    output logic                         s0_found,
    output logic [tlb_pkg::INDEX_W-1:0]  s0_index,
    output logic [tlb_pkg::PFN_W-1:0]    s0_pfn,
    output logic [tlb_pkg::CATTR_W-1:0]  s0_c,
    output logic                         s0_d,
    output logic                         s0_v,

    // search port 1
    input  wire  [tlb_pkg::VPN2_W-1:0]   s1_vpn2,
    input  wire                          s1_odd_page,
    input  wire  [tlb_pkg::ASID_W-1:0]   s1_asid,
    output logic                         s1_found,
    output logic [tlb_pkg::INDEX_W-1:0]  s1_index,
    output logic [tlb_pkg::PFN_W-1:0]    s1_pfn,
    output logic [tlb_pkg::CATTR_W-1:0]  s1_c,
    output logic                         s1_d,
    output logic                         s1_v,

    // write port
    input  wire                          we,
    input  wire  [tlb_pkg::INDEX_W-1:0]  w_index,
    input  wire  [tlb_pkg::VPN2_W-1:0]   w_vpn2,
    input  wire  [tlb_pkg::ASID_W-1:0]   w_asid,
    input  wire                          w_g,
    input  wire  [tlb_pkg::PFN_W-1:0]    w_pfn0,
    input  wire  [tlb_pkg::CATTR_W-1:0]  w_c0,
    input  wire                          w_d0,
    input  wire                          w_v0,
    input  wire  [tlb_pkg::PFN_W-1:0]    w_pfn1,
    input  wire  [tlb_pkg::CATTR_W-1:0]  w_c1,
    input  wire                          w_d1,
    input  wire                          w_v1,

    // read port
    input  wire  [tlb_pkg::INDEX_W-1:0]  r_index,
    output logic [tlb_pkg::VPN2_W-1:0]   r_vpn2,
    output logic [tlb_pkg::ASID_W-1:0]   r_asid,
    output logic                         r_g,
    output logic [tlb_pkg::PFN_W-1:0]    r_pfn0,
    output logic [tlb_pkg::CATTR_W-1:0]  r_c0,
    output logic                         r_d0,
    output logic                         r_v0,
    output logic [tlb_pkg::PFN_W-1:0]    r_pfn1,
    output logic [tlb_pkg::CATTR_W-1:0]  r_c1,
    output logic                         r_d1,
    output logic                         r_v1
);

    logic [tlb_pkg::TLB_NUM*tlb_pkg::VPN2_W-1:0]  entry_vpn2;
    logic [tlb_pkg::TLB_NUM*tlb_pkg::ASID_W-1:0]  entry_asid;
    logic [tlb_pkg::TLB_NUM-1:0]                  entry_g;
    logic [tlb_pkg::TLB_NUM*tlb_pkg::PFN_W-1:0]   entry_pfn0;
    logic [tlb_pkg::TLB_NUM*tlb_pkg::CATTR_W-1:0] entry_c0;
    logic [tlb_pkg::TLB_NUM-1:0]                  entry_d0;
    logic [tlb_pkg::TLB_NUM-1:0]                  entry_v0;
    logic [tlb_pkg::TLB_NUM*tlb_pkg::PFN_W-1:0]   entry_pfn1;
    logic [tlb_pkg::TLB_NUM*tlb_pkg::CATTR_W-1:0] entry_c1;
    logic [tlb_pkg::TLB_NUM-1:0]                  entry_d1;
    logic [tlb_pkg::TLB_NUM-1:0]                  entry_v1;

    logic [tlb_pkg::TLB_NUM-1:0]                  match0;
    logic [tlb_pkg::TLB_NUM-1:0]                  match1;

    tlb_entry_array u_entry_array (
        .clk        (clk),
        .rst        (rst),
        .we         (we),
        .w_index    (w_index),
        .w_vpn2     (w_vpn2),
        .w_asid     (w_asid),
        .w_g        (w_g),
        .w_pfn0     (w_pfn0),
        .w_c0       (w_c0),
        .w_d0       (w_d0),
        .w_v0       (w_v0),
        .w_pfn1     (w_pfn1),
        .w_c1       (w_c1),
        .w_d1       (w_d1),
        .w_v1       (w_v1),
        .r_index    (r_index),
        .r_vpn2     (r_vpn2),
        .r_asid     (r_asid),
        .r_g        (r_g),
        .r_pfn0     (r_pfn0),
        .r_c0       (r_c0),
        .r_d0       (r_d0),
        .r_v0       (r_v0),
        .r_pfn1     (r_pfn1),
        .r_c1       (r_c1),
        .r_d1       (r_d1),
        .r_v1       (r_v1),
        .entry_vpn2 (entry_vpn2),
        .entry_asid (entry_asid),
        .entry_g    (entry_g),
        .entry_pfn0 (entry_pfn0),
        .entry_c0   (entry_c0),
        .entry_d0   (entry_d0),
        .entry_v0   (entry_v0),
        .entry_pfn1 (entry_pfn1),
        .entry_c1   (entry_c1),
        .entry_d1   (entry_d1),
        .entry_v1   (entry_v1)
    );

    // search path 0
    tlb_match u_match0 (
        .vpn2       (s0_vpn2),
        .asid       (s0_asid),
        .entry_vpn2 (entry_vpn2),
        .entry_asid (entry_asid),
        .entry_g    (entry_g),
        .match      (match0),
        .found      (s0_found)
    );

    tlb_page_select u_select0 (
        .match      (match0),
        .odd_page   (s0_odd_page),
        .entry_pfn0 (entry_pfn0),
        .entry_c0   (entry_c0),
        .entry_d0   (entry_d0),
        .entry_v0   (entry_v0),
        .entry_pfn1 (entry_pfn1),
        .entry_c1   (entry_c1),
        .entry_d1   (entry_d1),
        .entry_v1   (entry_v1),
        .index      (s0_index),
        .pfn        (s0_pfn),
        .c          (s0_c),
        .d          (s0_d),
        .v          (s0_v)
    );

    // search path 1
    tlb_match u_match1 (
        .vpn2       (s1_vpn2),
        .asid       (s1_asid),
        .entry_vpn2 (entry_vpn2),
        .entry_asid (entry_asid),
        .entry_g    (entry_g),
        .match      (match1),
        .found      (s1_found)
    );

    tlb_page_select u_select1 (
        .match      (match1),
        .odd_page   (s1_odd_page),
        .entry_pfn0 (entry_pfn0),
        .entry_c0   (entry_c0),
        .entry_d0   (entry_d0),
        .entry_v0   (entry_v0),
        .entry_pfn1 (entry_pfn1),
        .entry_c1   (entry_c1),
        .entry_d1   (entry_d1),
        .entry_v1   (entry_v1),
        .index      (s1_index),
        .pfn        (s1_pfn),
        .c          (s1_c),
        .d          (s1_d),
        .v          (s1_v)
    );

endmodule

`default_nettype wire

// File: bench/tlb_properties.sv
`default_nettype none

module tlb_properties (
    input wire                                        clk,
    input wire                                        rst,
    input wire [tlb_pkg::VPN2_W-1:0]                  s0_vpn2, s1_vpn2, w_vpn2, r_vpn2,
    input wire [tlb_pkg::ASID_W-1:0]                  s0_asid, s1_asid, w_asid, r_asid,
    input wire [tlb_pkg::INDEX_W-1:0]                 s0_index, s1_index, w_index, r_index,
    input wire [tlb_pkg::PFN_W-1:0]                   s0_pfn, s1_pfn,
    input wire [tlb_pkg::CATTR_W-1:0]                 s0_c, s1_c,
    input wire                                        s0_odd_page, s0_found, s0_d, s0_v,
    input wire                                        s1_odd_page, s1_found, s1_d, s1_v,
    input wire                                        we, w_g, r_g,
    input wire [tlb_pkg::TLB_NUM*tlb_pkg::VPN2_W-1:0] entry_vpn2
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // a miss returns all-zero fields
    miss_zero0: assert property (@(posedge clk) disable iff (!rst)
        !s0_found |-> (s0_index == '0 && s0_pfn == '0 && s0_c == '0 && !s0_d && !s0_v))
    else begin
        $error("port 0 missed but returned nonzero fields");
        fail_count++;
    end

    miss_zero1: assert property (@(posedge clk) disable iff (!rst)
        !s1_found |-> (s1_index == '0 && s1_pfn == '0 && s1_c == '0 && !s1_d && !s1_v))
    else begin
        $error("port 1 missed but returned nonzero fields");
        fail_count++;
    end

    // entry written at one edge is readable in the next cycle
    write_read_back: assert property (@(posedge clk) disable iff (!rst)
        we ##1 (r_index == $past(w_index))
        |-> (r_vpn2 == $past(w_vpn2) && r_asid == $past(w_asid) && r_g == $past(w_g)))
    else begin
        $error("read after write returned different tag fields");
        fail_count++;
    end

    same_search: assert property (@(posedge clk) disable iff (!rst)
        (s0_vpn2 == s1_vpn2 && s0_asid == s1_asid && s0_odd_page == s1_odd_page)
        |-> ({s0_found, s0_index, s0_pfn, s0_c, s0_d, s0_v}
             == {s1_found, s1_index, s1_pfn, s1_c, s1_d, s1_v}))
    else begin
        $error("identical searches on both ports gave different results");
        fail_count++;
    end

    hit_tag0: assert property (@(posedge clk) disable iff (!rst)
        s0_found |-> (entry_vpn2[s0_index*tlb_pkg::VPN2_W +: tlb_pkg::VPN2_W] == s0_vpn2))
    else begin
        $error("port 0 hit index holds a different vpn2");
        fail_count++;
    end

    hit_tag1: assert property (@(posedge clk) disable iff (!rst)
        s1_found |-> (entry_vpn2[s1_index*tlb_pkg::VPN2_W +: tlb_pkg::VPN2_W] == s1_vpn2))
    else begin
        $error("port 1 hit index holds a different vpn2");
        fail_count++;
    end

endmodule

bind tlb_top tlb_properties u_tlb_properties (.*);

`default_nettype wire

// File: bench/tb_tlb.sv
`default_nettype none

module tb_tlb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 32'h97c;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_CYCLES  = 100;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD * 2;

    logic                        clk;
    logic                        rst;
    logic [tlb_pkg::VPN2_W-1:0]  s0_vpn2, s1_vpn2, w_vpn2, r_vpn2;
    logic [tlb_pkg::ASID_W-1:0]  s0_asid, s1_asid, w_asid, r_asid;
    logic [tlb_pkg::INDEX_W-1:0] s0_index, s1_index, w_index, r_index;
    logic [tlb_pkg::PFN_W-1:0]   s0_pfn, s1_pfn, w_pfn0, w_pfn1, r_pfn0, r_pfn1;
    logic [tlb_pkg::CATTR_W-1:0] s0_c, s1_c, w_c0, w_c1, r_c0, r_c1;
    logic                        s0_odd_page, s0_found, s0_d, s0_v;
    logic                        s1_odd_page, s1_found, s1_d, s1_v;
    logic                        we, w_g, w_d0, w_v0, w_d1, w_v1;
    logic                        r_g, r_d0, r_v0, r_d1, r_v1;

    // reference model indexed by entry and then by page half
    logic [tlb_pkg::VPN2_W-1:0]  m_vpn2 [tlb_pkg::TLB_NUM];
    logic [tlb_pkg::ASID_W-1:0]  m_asid [tlb_pkg::TLB_NUM];
    logic                        m_g    [tlb_pkg::TLB_NUM];
    logic [tlb_pkg::PFN_W-1:0]   m_pfn  [tlb_pkg::TLB_NUM][2];
    logic [tlb_pkg::CATTR_W-1:0] m_c    [tlb_pkg::TLB_NUM][2];
    logic                        m_d    [tlb_pkg::TLB_NUM][2];
    logic                        m_v    [tlb_pkg::TLB_NUM][2];

    int err_cnt = 0;
    int test_err_base = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    tlb_top u_tlb_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t and the tests did not finish", $time);
        $display("test failed");
        $finish;
    end

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("ERR %0t %s got %0h expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err_base)
            tests_ok++;
        else
            tests_bad++;
        $display("%s finished with %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // hit needs an equal vpn2 and an equal asid or a global entry
    function automatic logic model_lookup(input logic [tlb_pkg::VPN2_W-1:0] vpn2,
                                          input logic [tlb_pkg::ASID_W-1:0] asid,
                                          output int idx);
        logic hit;
        hit = 1'b0;
        idx = 0;
        for (int k = 0; k < tlb_pkg::TLB_NUM; k++) begin
            if (m_vpn2[k] == vpn2 && (m_asid[k] == asid || m_g[k])) begin
                hit = 1'b1;
                idx = k;
            end
        end
        return hit;
    endfunction

    task automatic check_search(input string port, input logic [tlb_pkg::VPN2_W-1:0] vpn2,
                                input logic odd, input logic [tlb_pkg::ASID_W-1:0] asid,
                                input logic found, input logic [tlb_pkg::INDEX_W-1:0] index,
                                input logic [tlb_pkg::PFN_W-1:0] pfn,
                                input logic [tlb_pkg::CATTR_W-1:0] c, input logic d,
                                input logic v);
        logic hit;
        int idx;
        hit = model_lookup(vpn2, asid, idx);
        expect_value({port, "_found"}, found, hit);
        expect_value({port, "_index"}, index, hit ? idx : 0);
        expect_value({port, "_pfn"}, pfn, hit ? m_pfn[idx][odd] : 0);
        expect_value({port, "_c"}, c, hit ? m_c[idx][odd] : 0);
        expect_value({port, "_d"}, d, hit ? m_d[idx][odd] : 0);
        expect_value({port, "_v"}, v, hit ? m_v[idx][odd] : 0);
    endtask

    task automatic search_pair(input logic [tlb_pkg::VPN2_W-1:0] va, input logic oa,
                               input logic [tlb_pkg::ASID_W-1:0] aa,
                               input logic [tlb_pkg::VPN2_W-1:0] vb, input logic ob,
                               input logic [tlb_pkg::ASID_W-1:0] ab);
        @(negedge clk);
        we = 1'b0;
        {s0_vpn2, s0_odd_page, s0_asid} = {va, oa, aa};
        {s1_vpn2, s1_odd_page, s1_asid} = {vb, ob, ab};
        @(posedge clk);
        check_search("s0", va, oa, aa, s0_found, s0_index, s0_pfn, s0_c, s0_d, s0_v);
        check_search("s1", vb, ob, ab, s1_found, s1_index, s1_pfn, s1_c, s1_d, s1_v);
    endtask

    task automatic compare_read(input int k);
        expect_value("r_vpn2", r_vpn2, m_vpn2[k]);
        expect_value("r_asid", r_asid, m_asid[k]);
        expect_value("r_g", r_g, m_g[k]);
        expect_value("r_pfn0", r_pfn0, m_pfn[k][0]);
        expect_value("r_c0", r_c0, m_c[k][0]);
        expect_value("r_d0", r_d0, m_d[k][0]);
        expect_value("r_v0", r_v0, m_v[k][0]);
        expect_value("r_pfn1", r_pfn1, m_pfn[k][1]);
        expect_value("r_c1", r_c1, m_c[k][1]);
        expect_value("r_d1", r_d1, m_d[k][1]);
        expect_value("r_v1", r_v1, m_v[k][1]);
    endtask

    task automatic read_check(input int k);
        @(negedge clk);
        we = 1'b0;
        r_index = k[tlb_pkg::INDEX_W-1:0];
        @(posedge clk);
        compare_read(k);
    endtask

    task automatic write_random_entry(input int k, input logic [tlb_pkg::VPN2_W-1:0] vpn2,
                                      input logic [tlb_pkg::ASID_W-1:0] asid,
                                      input logic g);
        @(negedge clk);
        {we, w_index, w_vpn2, w_asid, w_g} = {1'b1, k[tlb_pkg::INDEX_W-1:0], vpn2, asid, g};
        w_pfn0 = $urandom;
        w_pfn1 = $urandom;
        {w_c0, w_c1, w_d0, w_v0, w_d1, w_v1} = $urandom;
        r_index = k[tlb_pkg::INDEX_W-1:0];
        @(posedge clk);
        // the read port still holds the old entry at the write edge
        compare_read(k);
        {m_vpn2[k], m_asid[k], m_g[k]} = {w_vpn2, w_asid, w_g};
        {m_pfn[k][0], m_c[k][0], m_d[k][0], m_v[k][0]} = {w_pfn0, w_c0, w_d0, w_v0};
        {m_pfn[k][1], m_c[k][1], m_d[k][1], m_v[k][1]} = {w_pfn1, w_c1, w_d1, w_v1};
    endtask

    task automatic pick_fresh_vpn2(output logic [tlb_pkg::VPN2_W-1:0] v);
        logic clash;
        do begin
            v = $urandom_range((1 << tlb_pkg::VPN2_W) - 1, 1);
            clash = 1'b0;
            for (int k = 0; k < tlb_pkg::TLB_NUM; k++) begin
                if (m_vpn2[k] == v)
                    clash = 1'b1;
            end
        end while (clash);
    endtask

    initial begin
        logic [tlb_pkg::VPN2_W-1:0] v;
        logic [tlb_pkg::VPN2_W-1:0] old_v;
        logic [tlb_pkg::ASID_W-1:0] a;
        int k;
        void'($urandom(SEED));
        m_vpn2 = '{default: '0};
        m_asid = '{default: '0};
        m_g    = '{default: '0};
        m_pfn  = '{default: '0};
        m_c    = '{default: '0};
        m_d    = '{default: '0};
        m_v    = '{default: '0};
        rst = 1'b0;
        {s0_odd_page, s0_asid, s1_odd_page, s1_asid} = '0;
        // idle searches keep off the all-zero tag of cleared entries
        s0_vpn2 = '1;
        s1_vpn2 = '1;
        {we, w_index, w_vpn2, w_asid, w_g, r_index} = '0;
        {w_pfn0, w_c0, w_d0, w_v0, w_pfn1, w_c1, w_d1, w_v1} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // nonzero vpn2 never matches a cleared entry
        for (k = 0; k < tlb_pkg::TLB_NUM; k++) begin
            v = $urandom_range((1 << tlb_pkg::VPN2_W) - 2, 1);
            a = $urandom;
            if (k % 2 == 0)
                search_pair(v, k[1], a, v, k[1], a);
            else
                search_pair(v, 1'b0, a, v + 1'b1, 1'b1, a);
        end
        for (k = 0; k < tlb_pkg::TLB_NUM; k++)
            read_check(k);
        end_test("after_reset");

        for (k = 0; k < tlb_pkg::TLB_NUM; k++) begin
            pick_fresh_vpn2(v);
            write_random_entry(k, v, $urandom, k % 3 == 0);
        end
        for (k = 0; k < tlb_pkg::TLB_NUM; k++)
            read_check(k);
        end_test("write_readback");

        for (k = 0; k < tlb_pkg::TLB_NUM; k++)
            search_pair(m_vpn2[k], 1'b0, m_asid[k], m_vpn2[k], 1'b1, m_asid[k]);
        end_test("search_hits");

        // only global entries hit under a foreign asid
        for (k = 0; k < tlb_pkg::TLB_NUM; k++) begin
            a = m_asid[k] ^ $urandom_range(255, 1);
            search_pair(m_vpn2[k], k[0], a, m_vpn2[k], k[0], a);
        end
        end_test("asid_global");

        k = $urandom_range(tlb_pkg::TLB_NUM - 1, 0);
        old_v = m_vpn2[k];
        a = m_asid[k];
        pick_fresh_vpn2(v);
        write_random_entry(k, v, a, 1'b0);
        read_check(k);
        search_pair(old_v, 1'b0, a, v, 1'b1, a);
        end_test("overwrite");

        // let the last edge's assertions settle
        @(negedge clk);
        $display("%0d tests clean, %0d tests with errors, %0d assertion failures",
                 tests_ok, tests_bad, u_tlb_top.u_tlb_properties.fail_count);
        if (tests_bad == 0 && u_tlb_top.u_tlb_properties.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
source/tlb_pkg.sv
source/tlb_entry_array.sv
source/tlb_match.sv
source/tlb_page_select.sv
source/tlb_top.sv
bench/tlb_properties.sv
bench/tb_tlb.sv
